/* source/aes_pkg.sv */
`default_nettype none

package aes_pkg;

	////////////////////////////////////////
	// Geometry of the AES state
	////////////////////////////////////////
	localparam int BYTE_W     = 8;
	localparam int WORD_BYTES = 4;
	localparam int STATE_ROWS = 4;
	localparam int STATE_COLS = 4;
	localparam int NUM_ROUNDS = 10;  // Rounds with a defined Rcon

	typedef logic [BYTE_W-1:0] byte_t;
	typedef byte_t [WORD_BYTES-1:0] word_t;  // Column word, index 0 is row 0
	typedef byte_t [STATE_COLS-1:0] row_t;   // Index c is column c
	typedef row_t [STATE_ROWS-1:0] state_t;  // Row 0 sits in bits 31:0
	typedef logic [3:0] round_t;

	typedef struct packed {
		state_t add_round_key;
		state_t shift_rows;
		state_t mix_columns;
		state_t sub_bytes;
		state_t next_key;
	} round_results_t;

	////////////////////////////////////////
	// Forward S-box
	////////////////////////////////////////
	localparam byte_t SBOX [256] = '{
		8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
		8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
		8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
		8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
		8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
		8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
		8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
		8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
		8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
		8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
		8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
		8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
		8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
		8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
		8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
		8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
		8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
		8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
		8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
		8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
		8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
		8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
		8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
		8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
		8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
		8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
		8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
		8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
		8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
		8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
		8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
		8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
	};

	////////////////////////////////////////
	// Round constants, round 0 first
	////////////////////////////////////////
	localparam byte_t RCON [NUM_ROUNDS] = '{
		8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
		8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
	};

endpackage

`default_nettype wire

/* source/sub_bytes.sv */
`timescale 1ns/10ps
`default_nettype none

module sub_bytes #(
	parameter type payload_t = aes_pkg::state_t
) (
	input  payload_t data_in,
	output payload_t data_out
);

	import aes_pkg::*;

	logic [$bits(payload_t)-1:0] bits_in;   // Flat view of the payload
	logic [$bits(payload_t)-1:0] bits_out;

	assign bits_in = data_in;

	// One table lookup per byte, any payload width in whole bytes
	always_comb begin
		bits_out = '0;
		for (int i = 0; i < $bits(payload_t) / BYTE_W; i++) begin
			bits_out[i*BYTE_W +: BYTE_W] = SBOX[bits_in[i*BYTE_W +: BYTE_W]];
		end
	end

	assign data_out = payload_t'(bits_out);

endmodule

`default_nettype wire

/* source/mix_columns.sv */
`timescale 1ns/10ps
`default_nettype none

module mix_columns (
	input  aes_pkg::state_t state_in,
	output aes_pkg::state_t state_out
);

	import aes_pkg::*;

	////////////////////////////////////////
	// GF(2^8) helpers
	////////////////////////////////////////
	function automatic byte_t xtime(input byte_t b);
		byte_t doubled;
		doubled = {b[BYTE_W-2:0], 1'b0};
		if (b[BYTE_W-1]) begin
			doubled = doubled ^ 8'h1b;  // Reduce by the AES polynomial
		end
		return doubled;
	endfunction

	function automatic byte_t mul3(input byte_t b);
		return xtime(b) ^ b;
	endfunction

	////////////////////////////////////////
	// Column mixing
	////////////////////////////////////////
	always_comb begin
		byte_t b0;
		byte_t b1;
		byte_t b2;
		byte_t b3;
		state_out = '0;
		for (int c = 0; c < STATE_COLS; c++) begin
			for (int r = 0; r < STATE_ROWS; r++) begin
				b0 = state_in[r][c];                      // Factor 2
				b1 = state_in[(r + 1) % STATE_ROWS][c];   // Factor 3
				b2 = state_in[(r + 2) % STATE_ROWS][c];
				b3 = state_in[(r + 3) % STATE_ROWS][c];
				state_out[r][c] = xtime(b0) ^ mul3(b1) ^ b2 ^ b3;
			end
		end
	end

endmodule

`default_nettype wire

/* source/key_expand.sv */
`timescale 1ns/10ps
`default_nettype none

module key_expand (
	input  aes_pkg::state_t key_in,
	input  aes_pkg::round_t round,
	output aes_pkg::state_t next_key
);

	import aes_pkg::*;

	word_t rot_word;   // RotWord of key column 3
	word_t sub_word;   // After the S-box
	word_t temp_word;  // After Rcon
	byte_t rcon_byte;

	// Column 3 moved up one row
	always_comb begin
		for (int r = 0; r < WORD_BYTES; r++) begin
			rot_word[r] = key_in[(r + 1) % STATE_ROWS][STATE_COLS-1];
		end
	end

	sub_bytes #(
		.payload_t(word_t)
	) sub_word_i (
		.data_in (rot_word),
		.data_out(sub_word)
	);

	// Rounds past the table get no constant
	assign rcon_byte = (round < NUM_ROUNDS) ? RCON[round] : '0;

	always_comb begin
		temp_word    = sub_word;
		temp_word[0] = sub_word[0] ^ rcon_byte;
	end

	////////////////////////////////////////
	// Column chain
	////////////////////////////////////////
	always_comb begin
		next_key = '0;
		for (int r = 0; r < STATE_ROWS; r++) begin
			next_key[r][0] = key_in[r][0] ^ temp_word[r];
		end
		for (int c = 1; c < STATE_COLS; c++) begin
			for (int r = 0; r < STATE_ROWS; r++) begin
				next_key[r][c] = key_in[r][c] ^ next_key[r][c-1];  // Previous new column
			end
		end
	end

endmodule

`default_nettype wire

/* source/round_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module round_stage (
	input  logic                   clk,
	input  logic                   reset,
	input  aes_pkg::state_t        state_in,
	input  aes_pkg::state_t        key_in,
	input  aes_pkg::state_t        sub_state,
	input  aes_pkg::state_t        mixed_state,
	input  aes_pkg::state_t        next_key,
	output aes_pkg::round_results_t results
);

	import aes_pkg::*;

	state_t shifted;  // ShiftRows of the state
	state_t keyed;    // AddRoundKey of the state

	////////////////////////////////////////
	// ShiftRows and AddRoundKey
	////////////////////////////////////////
	always_comb begin
		for (int r = 0; r < STATE_ROWS; r++) begin
			for (int c = 0; c < STATE_COLS; c++) begin
				shifted[r][c] = state_in[r][(c + r) % STATE_COLS];  // Row r rotates left by r
			end
		end
	end

	assign keyed = state_in ^ key_in;

	////////////////////////////////////////
	// Output register
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			results <= '0;
		end else begin
			results <= '{
				add_round_key: keyed,
				shift_rows:    shifted,
				mix_columns:   mixed_state,
				sub_bytes:     sub_state,
				next_key:      next_key
			};
		end
	end

endmodule

`default_nettype wire

/* source/aes_round_ops.sv */
`timescale 1ns/10ps
`default_nettype none

module aes_round_ops (
	input  logic                   clk,
	input  logic                   reset,
	input  aes_pkg::state_t        state_in,
	input  aes_pkg::state_t        key_in,
	input  aes_pkg::round_t        round,
	output aes_pkg::round_results_t results
);

	import aes_pkg::*;

	state_t sub_state;    // SubBytes of the state
	state_t mixed_state;  // MixColumns of the state
	state_t next_key;     // Expanded round key

	sub_bytes #(
		.payload_t(state_t)
	) sub_bytes_i (
		.data_in (state_in),
		.data_out(sub_state)
	);

	mix_columns mix_columns_i (
		.state_in (state_in),
		.state_out(mixed_state)
	);

	key_expand key_expand_i (
		.key_in  (key_in),
		.round   (round),
		.next_key(next_key)
	);

	// All five results leave through one register
	round_stage round_stage_i (
		.clk        (clk),
		.reset      (reset),
		.state_in   (state_in),
		.key_in     (key_in),
		.sub_state  (sub_state),
		.mixed_state(mixed_state),
		.next_key   (next_key),
		.results    (results)
	);

endmodule

`default_nettype wire

/* verification/aes_round_ops_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module aes_round_ops_tb;

	import aes_pkg::*;

	localparam int CLK_NS       = 8;
	localparam int RESET_CYCLES = 3;
	localparam int NUM_RANDOM   = 300;
	localparam int NUM_B2B      = 64;
	// Reset, known vector with drain, random run with drain, back-to-back with drain
	localparam int TOTAL_CYCLES = RESET_CYCLES + 2 + NUM_RANDOM + 1 + NUM_B2B + 1;

	logic           clk;
	logic           reset;
	state_t         state_in;
	state_t         key_in;
	round_t         round;
	round_results_t results;

	byte_t       sbox_m [256];  // Built from the field inverse
	byte_t       rcon_m [16];   // Zero past round 9
	logic [31:0] rng_state = 32'hbdd6;

	state_t prev_state;  // Inputs that the register holds now
	state_t prev_key;
	round_t prev_round;
	logic   have_prev;
	int     state_errs = 0;
	int     key_errs   = 0;
	int     misc_errs  = 0;
	int     pass_count = 0;
	int     fail_count = 0;

	aes_round_ops aes_round_ops_i (
		.clk     (clk),
		.reset   (reset),
		.state_in(state_in),
		.key_in  (key_in),
		.round   (round),
		.results (results)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	////////////////////////////////////////
	// Random numbers
	////////////////////////////////////////
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic state_t random_state();
		return {next_random(), next_random(), next_random(), next_random()};
	endfunction

	function automatic round_t random_round();
		logic [31:0] r;
		r = next_random();
		if (r[4:2] == 3'd0) begin
			return round_t'(10 + r[31:8] % 6);  // About one in eight past the table
		end
		return round_t'(r[31:8] % 10);
	endfunction

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////
	function automatic byte_t double_byte(input byte_t b);
		return b[7] ? ((b << 1) ^ 8'h1b) : (b << 1);
	endfunction

	function automatic byte_t multiply(input byte_t a, input byte_t b);
		byte_t acc;
		byte_t x;
		acc = '0;
		x   = a;
		for (int i = 0; i < 8; i++) begin
			if (b[i]) begin
				acc = acc ^ x;
			end
			x = double_byte(x);
		end
		return acc;
	endfunction

	// b xor its rotations by 1 to 4, then 63
	function automatic byte_t affine(input byte_t b);
		byte_t s;
		s = 8'h63;
		for (int i = 0; i < 5; i++) begin
			s = s ^ ((b << i) | (b >> (8 - i)));
		end
		return s;
	endfunction

	task automatic build_tables();
		byte_t inv;
		for (int i = 0; i < 256; i++) begin
			inv = '0;  // Zero has no inverse and maps to zero
			for (int j = 1; j < 256; j++) begin
				if (multiply(byte_t'(i), byte_t'(j)) == 8'h01) begin
					inv = byte_t'(j);
				end
			end
			sbox_m[i] = affine(inv);
		end
		rcon_m[0] = 8'h01;
		for (int i = 1; i < 16; i++) begin
			rcon_m[i] = (i < NUM_ROUNDS) ? double_byte(rcon_m[i-1]) : 8'h00;
		end
	endtask

	function automatic round_results_t expected(input state_t s, input state_t k, input round_t rd);
		round_results_t e;
		byte_t          w [4];
		for (int r = 0; r < 4; r++) begin
			for (int c = 0; c < 4; c++) begin
				e.add_round_key[r][c] = s[r][c] ^ k[r][c];
				e.shift_rows[r][c]    = s[r][(c + r) % 4];
				e.sub_bytes[r][c]     = sbox_m[s[r][c]];
				e.mix_columns[r][c]   = multiply(8'h02, s[r][c]) ^ multiply(8'h03, s[(r + 1) % 4][c])
					^ s[(r + 2) % 4][c] ^ s[(r + 3) % 4][c];
			end
		end
		for (int r = 0; r < 4; r++) begin
			w[r] = sbox_m[k[(r + 1) % 4][3]];  // RotWord then SubWord
		end
		w[0] = w[0] ^ rcon_m[rd];
		for (int r = 0; r < 4; r++) begin
			e.next_key[r][0] = k[r][0] ^ w[r];
		end
		for (int c = 1; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				e.next_key[r][c] = k[r][c] ^ e.next_key[r][c-1];
			end
		end
		return e;
	endfunction

	////////////////////////////////////////
	// Checking
	////////////////////////////////////////
	function automatic int field_mismatch(input string name, input state_t got, input state_t want);
		int bad;
		bad = 0;
		assert (got === want) else begin
			$display("FAIL %0t: %s is %h, expected %h", $time, name, got, want);
			bad = 1;
		end
		return bad;
	endfunction

	task automatic check_results(input state_t s, input state_t k, input round_t rd);
		round_results_t e;
		e = expected(s, k, rd);
		state_errs += field_mismatch("add_round_key", results.add_round_key, e.add_round_key);
		state_errs += field_mismatch("shift_rows", results.shift_rows, e.shift_rows);
		state_errs += field_mismatch("sub_bytes", results.sub_bytes, e.sub_bytes);
		state_errs += field_mismatch("mix_columns", results.mix_columns, e.mix_columns);
		key_errs   += field_mismatch("next_key", results.next_key, e.next_key);
	endtask

	// New inputs on the edge, last cycle's inputs checked half a cycle later
	task automatic apply(input state_t s, input state_t k, input round_t rd);
		@(posedge clk);
		state_in <= s;
		key_in   <= k;
		round    <= rd;
		@(negedge clk);
		if (have_prev) begin
			check_results(prev_state, prev_key, prev_round);
		end
		prev_state = s;
		prev_key   = k;
		prev_round = rd;
		have_prev  = 1'b1;
	endtask

	task automatic drain();
		@(posedge clk);
		@(negedge clk);
		if (have_prev) begin
			check_results(prev_state, prev_key, prev_round);
		end
		have_prev = 1'b0;
	endtask

	task automatic report_test(input string name, input int errs);
		if (errs == 0) begin
			pass_count++;
			$display("%s: passed", name);
		end else begin
			fail_count++;
			$display("%s: failed with %0d errors", name, errs);
		end
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////
	initial begin
		state_t s;
		state_t k;
		round_t rd;
		state_t s1;
		state_t k1;
		state_t s2;
		state_t k2;
		int     high_rounds;
		int     snap;
		int     snap_state;
		int     snap_key;
		reset     = 1'b1;
		state_in  = random_state();  // Nonzero so reset has something to clear
		key_in    = random_state();
		round     = '0;
		have_prev = 1'b0;
		build_tables();

		snap = misc_errs;
		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(posedge clk);
			if (i == RESET_CYCLES - 1) begin
				reset <= 1'b0;
			end
			@(negedge clk);
			assert (results === '0) else begin
				$display("FAIL %0t: results are %h during reset, expected zero", $time, results);
				misc_errs++;
			end
		end
		report_test("reset", misc_errs - snap);

		// FIPS-197 MixColumns example in column 0
		snap    = state_errs + key_errs + misc_errs;
		s       = '0;
		s[0][0] = 8'hdb;
		s[1][0] = 8'h13;
		s[2][0] = 8'h53;
		s[3][0] = 8'h45;
		apply(s, random_state(), 4'd0);
		drain();
		assert ({results.mix_columns[0][0], results.mix_columns[1][0], results.mix_columns[2][0],
			results.mix_columns[3][0]} == 32'h8e4da1bc) else begin
			$display("FAIL %0t: mix_columns column 0 differs from 8e 4d a1 bc", $time);
			misc_errs++;
		end
		assert (results.sub_bytes[2][0] == 8'hed && results.sub_bytes[0][1] == 8'h63) else begin
			$display("FAIL %0t: sub_bytes of 53 or 00 differs from ed or 63", $time);
			misc_errs++;
		end
		report_test("known vectors", state_errs + key_errs + misc_errs - snap);

		snap_state  = state_errs;
		snap_key    = key_errs;
		high_rounds = 0;
		for (int i = 0; i < NUM_RANDOM; i++) begin
			s  = random_state();
			k  = random_state();
			rd = random_round();
			if (rd >= NUM_ROUNDS) begin
				high_rounds++;
			end
			apply(s, k, rd);
		end
		drain();
		report_test("random state operations", state_errs - snap_state);
		assert (high_rounds > 0) else begin
			$display("No round number from 10 to 15 was generated in the random run");
			key_errs++;
		end
		report_test("key expansion", key_errs - snap_key);

		// Every round value in turn, inputs new on every edge
		snap = state_errs + key_errs + misc_errs;
		s1   = '0;
		k1   = '0;
		s2   = '0;
		k2   = '0;
		for (int i = 0; i < NUM_B2B; i++) begin
			s  = random_state();
			k  = random_state();
			rd = round_t'(i % 16);
			apply(s, k, rd);
			if (i >= 2) begin
				assert (results.add_round_key !== (s ^ k)) else begin
					$display("FAIL %0t: result already shows the inputs of this cycle", $time);
					misc_errs++;
				end
				assert (results.add_round_key !== (s2 ^ k2)) else begin
					$display("FAIL %0t: result still shows the inputs of two cycles back", $time);
					misc_errs++;
				end
			end
			s2 = s1;
			k2 = k1;
			s1 = s;
			k1 = k;
		end
		drain();
		report_test("back-to-back changes", state_errs + key_errs + misc_errs - snap);

		$display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	initial begin
		#((TOTAL_CYCLES + 100) * CLK_NS);
		$display("Watchdog expired before the tests finished");
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
source/aes_pkg.sv
source/sub_bytes.sv
source/mix_columns.sv
source/key_expand.sv
source/round_stage.sv
source/aes_round_ops.sv
verification/aes_round_ops_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the AES round operations testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f sources.f --top-module aes_round_ops_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vaes_round_ops_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "TB PASSED"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
